/* core_isa_pkg.sv */
package core_isa_pkg;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl and sra share it
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // same codes as branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_op_e;

endpackage

/* core_pipe_pkg.sv */
package core_pipe_pkg;

    typedef struct packed {
        logic                  valid;
        logic [31:0]           pc;
        logic [4:0]            rd;
        logic                  wen;
        logic [31:0]           op_a;
        logic [31:0]           op_b;
        logic [31:0]           imm;
        core_isa_pkg::alu_op_e alu_op;
        logic                  is_branch;
        core_isa_pkg::br_op_e  br_op;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  illegal;
        logic [31:0]           rs2_val; // rs2 for branch compare
    } dec_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wen;
        logic        link; // jal or jalr
        logic        illegal;
        logic [31:0] alu_res;
        logic [31:0] link_val;
    } ex_res_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] value;
    } fwd_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wen;
        logic        illegal;
        logic [31:0] wdata;
    } retire_t;

endpackage

/* core_regfile.sv */
module core_regfile (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [4:0]  raddr_a_i,
    input  logic [4:0]  raddr_b_i,
    input  logic        wen_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);
    logic [31:0] regs_q [1:31]; // no storage for x0
    logic        wr_live;

    assign wr_live = wen_i && (waddr_i != 5'd0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_live) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // write-through so a same-cycle reader sees the new value
    assign rdata_a_o = (raddr_a_i == 5'd0)                   ? 32'd0   :
                       (wr_live && (waddr_i == raddr_a_i))   ? wdata_i :
                                                               regs_q[raddr_a_i];

    assign rdata_b_o = (raddr_b_i == 5'd0)                   ? 32'd0   :
                       (wr_live && (waddr_i == raddr_b_i))   ? wdata_i :
                                                               regs_q[raddr_b_i];

endmodule

/* core_decode.sv */
module core_decode #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     inst_valid_i,
    input  logic [31:0]              inst_i,
    input  logic [31:0]              rdata_a_i,
    input  logic [31:0]              rdata_b_i,
    input  core_pipe_pkg::fwd_t      fwd_i,
    input  core_pipe_pkg::redirect_t redirect_i,
    output logic [31:0]              fetch_pc_o,
    output logic [4:0]               raddr_a_o,
    output logic [4:0]               raddr_b_o,
    output core_pipe_pkg::dec_ex_t   dec_o
);
    logic [31:0]            pc_q;
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic [31:0]            imm_i;
    logic [31:0]            imm_b;
    logic [31:0]            imm_u;
    logic [31:0]            imm_j;
    logic [31:0]            rs1_val;
    logic [31:0]            rs2_val;
    core_pipe_pkg::dec_ex_t dec_d;
    core_pipe_pkg::dec_ex_t dec_q;

    function automatic core_isa_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            core_isa_pkg::F3_ADD:  alu_sel = alt ? core_isa_pkg::ALU_SUB : core_isa_pkg::ALU_ADD;
            core_isa_pkg::F3_SLL:  alu_sel = core_isa_pkg::ALU_SLL;
            core_isa_pkg::F3_SLT:  alu_sel = core_isa_pkg::ALU_SLT;
            core_isa_pkg::F3_SLTU: alu_sel = core_isa_pkg::ALU_SLTU;
            core_isa_pkg::F3_XOR:  alu_sel = core_isa_pkg::ALU_XOR;
            core_isa_pkg::F3_SR:   alu_sel = alt ? core_isa_pkg::ALU_SRA : core_isa_pkg::ALU_SRL;
            core_isa_pkg::F3_OR:   alu_sel = core_isa_pkg::ALU_OR;
            core_isa_pkg::F3_AND:  alu_sel = core_isa_pkg::ALU_AND;
            default:               alu_sel = core_isa_pkg::ALU_ADD;
        endcase
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'd0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // execute result wins over the register file
    assign rs1_val = (fwd_i.valid && fwd_i.rd == rs1 && rs1 != 5'd0) ? fwd_i.value : rdata_a_i;
    assign rs2_val = (fwd_i.valid && fwd_i.rd == rs2 && rs2 != 5'd0) ? fwd_i.value : rdata_b_i;

    always_comb begin
        dec_d         = '0;
        dec_d.valid   = inst_valid_i & ~redirect_i.taken; // squash wrong path
        dec_d.pc      = pc_q;
        dec_d.rd      = inst_i[11:7];
        dec_d.op_a    = rs1_val;
        dec_d.op_b    = rs2_val;
        dec_d.rs2_val = rs2_val;
        dec_d.alu_op  = core_isa_pkg::ALU_ADD;
        dec_d.br_op   = core_isa_pkg::br_op_e'(funct3);
        case (opcode)
            core_isa_pkg::OPC_LUI: begin
                dec_d.wen    = 1'b1;
                dec_d.imm    = imm_u;
                dec_d.op_b   = imm_u;
                dec_d.alu_op = core_isa_pkg::ALU_PASS_B;
            end
            core_isa_pkg::OPC_AUIPC: begin
                dec_d.wen  = 1'b1;
                dec_d.imm  = imm_u;
                dec_d.op_a = pc_q;
                dec_d.op_b = imm_u;
            end
            core_isa_pkg::OPC_JAL: begin
                dec_d.wen    = 1'b1;
                dec_d.imm    = imm_j;
                dec_d.is_jal = 1'b1;
            end
            core_isa_pkg::OPC_JALR: begin
                dec_d.wen     = 1'b1;
                dec_d.imm     = imm_i;
                dec_d.is_jalr = 1'b1;
                dec_d.illegal = (funct3 != 3'b000);
            end
            core_isa_pkg::OPC_BRANCH: begin
                dec_d.imm       = imm_b;
                dec_d.is_branch = 1'b1;
                dec_d.illegal   = (funct3[2:1] == 2'b01); // 010 and 011 unused
            end
            core_isa_pkg::OPC_OPIMM: begin
                dec_d.wen     = 1'b1;
                dec_d.imm     = imm_i;
                dec_d.op_b    = imm_i;
                dec_d.alu_op  = alu_sel(funct3, funct3 == core_isa_pkg::F3_SR &&
                                                funct7 == core_isa_pkg::F7_ALT);
                dec_d.illegal = (funct3 == core_isa_pkg::F3_SLL &&
                                 funct7 != core_isa_pkg::F7_BASE) ||
                                (funct3 == core_isa_pkg::F3_SR &&
                                 funct7 != core_isa_pkg::F7_BASE &&
                                 funct7 != core_isa_pkg::F7_ALT);
            end
            core_isa_pkg::OPC_OP: begin
                dec_d.wen     = 1'b1;
                dec_d.alu_op  = alu_sel(funct3, funct7 == core_isa_pkg::F7_ALT);
                dec_d.illegal = !(funct7 == core_isa_pkg::F7_BASE ||
                                  (funct7 == core_isa_pkg::F7_ALT &&
                                   (funct3 == core_isa_pkg::F3_ADD ||
                                    funct3 == core_isa_pkg::F3_SR)));
            end
            default: dec_d.illegal = 1'b1;
        endcase
        if (dec_d.illegal) begin
            dec_d.wen       = 1'b0; // retires as a no-op
            dec_d.is_branch = 1'b0;
            dec_d.is_jal    = 1'b0;
            dec_d.is_jalr   = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i.taken) begin
            pc_q <= redirect_i.target;
        end else if (inst_valid_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q <= dec_d;
        end
    end

    assign fetch_pc_o = pc_q;
    assign raddr_a_o  = rs1;
    assign raddr_b_o  = rs2;
    assign dec_o      = dec_q;

endmodule

/* core_execute.sv */
module core_execute (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  core_pipe_pkg::dec_ex_t   dec_i,
    output core_pipe_pkg::fwd_t      fwd_o,
    output core_pipe_pkg::redirect_t redirect_o,
    output core_pipe_pkg::ex_res_t   res_o
);
    logic [31:0]            alu_res;
    logic [4:0]             shamt;
    logic                   br_cond;
    logic                   link;
    logic [31:0]            link_val;
    logic [31:0]            pc_target;
    logic [31:0]            jalr_sum;
    core_pipe_pkg::ex_res_t res_d;
    core_pipe_pkg::ex_res_t res_q;

    assign shamt = dec_i.op_b[4:0];

    always_comb begin
        case (dec_i.alu_op)
            core_isa_pkg::ALU_ADD:    alu_res = dec_i.op_a + dec_i.op_b;
            core_isa_pkg::ALU_SUB:    alu_res = dec_i.op_a - dec_i.op_b;
            core_isa_pkg::ALU_SLL:    alu_res = dec_i.op_a << shamt;
            core_isa_pkg::ALU_SLT:    alu_res = {31'd0, $signed(dec_i.op_a) < $signed(dec_i.op_b)};
            core_isa_pkg::ALU_SLTU:   alu_res = {31'd0, dec_i.op_a < dec_i.op_b};
            core_isa_pkg::ALU_XOR:    alu_res = dec_i.op_a ^ dec_i.op_b;
            core_isa_pkg::ALU_SRL:    alu_res = dec_i.op_a >> shamt;
            core_isa_pkg::ALU_SRA:    alu_res = $unsigned($signed(dec_i.op_a) >>> shamt);
            core_isa_pkg::ALU_OR:     alu_res = dec_i.op_a | dec_i.op_b;
            core_isa_pkg::ALU_AND:    alu_res = dec_i.op_a & dec_i.op_b;
            core_isa_pkg::ALU_PASS_B: alu_res = dec_i.op_b; // lui
            default:                  alu_res = 32'd0;
        endcase
    end

    // compare on the raw register values
    always_comb begin
        case (dec_i.br_op)
            core_isa_pkg::BR_EQ:  br_cond = (dec_i.op_a == dec_i.rs2_val);
            core_isa_pkg::BR_NE:  br_cond = (dec_i.op_a != dec_i.rs2_val);
            core_isa_pkg::BR_LT:  br_cond = ($signed(dec_i.op_a) < $signed(dec_i.rs2_val));
            core_isa_pkg::BR_GE:  br_cond = ($signed(dec_i.op_a) >= $signed(dec_i.rs2_val));
            core_isa_pkg::BR_LTU: br_cond = (dec_i.op_a < dec_i.rs2_val);
            core_isa_pkg::BR_GEU: br_cond = (dec_i.op_a >= dec_i.rs2_val);
            default:              br_cond = 1'b0;
        endcase
    end

    assign link      = dec_i.is_jal | dec_i.is_jalr;
    assign link_val  = dec_i.pc + 32'd4;
    assign pc_target = dec_i.pc + dec_i.imm; // branch and jal
    assign jalr_sum  = dec_i.op_a + dec_i.imm;

    assign redirect_o.taken  = dec_i.valid & ((dec_i.is_branch & br_cond) | link);
    assign redirect_o.target = dec_i.is_jalr ? {jalr_sum[31:1], 1'b0} : pc_target;

    assign fwd_o.valid = dec_i.valid & dec_i.wen;
    assign fwd_o.rd    = dec_i.rd;
    assign fwd_o.value = link ? link_val : alu_res;

    always_comb begin
        res_d.valid    = dec_i.valid;
        res_d.pc       = dec_i.pc;
        res_d.rd       = dec_i.rd;
        res_d.wen      = dec_i.wen;
        res_d.link     = link;
        res_d.illegal  = dec_i.illegal;
        res_d.alu_res  = alu_res;
        res_d.link_val = link_val;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_q.valid <= 1'b0;
        end else begin
            res_q <= res_d;
        end
    end

    assign res_o = res_q;

endmodule

/* core_result.sv */
module core_result (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  core_pipe_pkg::ex_res_t res_i,
    output logic                   rf_wen_o,
    output logic [4:0]             rf_waddr_o,
    output logic [31:0]            rf_wdata_o,
    output core_pipe_pkg::retire_t retire_o
);
    logic        commit;
    logic        wen;
    logic [31:0] wdata;

    assign commit = res_i.valid;
    assign wdata  = res_i.link ? res_i.link_val : res_i.alu_res;

    // x0 and illegal records never write
    assign wen = commit & res_i.wen & ~res_i.illegal & (res_i.rd != 5'd0);

    assign rf_wen_o   = wen;
    assign rf_waddr_o = res_i.rd;
    assign rf_wdata_o = wdata;

    always_comb begin
        retire_o.valid   = commit;
        retire_o.pc      = res_i.pc;
        retire_o.rd      = res_i.rd;
        retire_o.wen     = wen;
        retire_o.illegal = res_i.illegal;
        retire_o.wdata   = wdata;
    end

endmodule

/* core_top.sv */
module core_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   inst_valid_i,
    input  logic [31:0]            inst_i,
    output logic [31:0]            fetch_pc_o,
    output core_pipe_pkg::retire_t retire_o
);
    logic [4:0]               raddr_a;
    logic [4:0]               raddr_b;
    logic [31:0]              rdata_a;
    logic [31:0]              rdata_b;
    core_pipe_pkg::dec_ex_t   dec;
    core_pipe_pkg::fwd_t      fwd;
    core_pipe_pkg::redirect_t redirect;
    core_pipe_pkg::ex_res_t   res;
    logic                     rf_wen;
    logic [4:0]               rf_waddr;
    logic [31:0]              rf_wdata;

    core_decode #(
        .RESET_PC (RESET_PC)
    ) u_decode (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rdata_a_i    (rdata_a),
        .rdata_b_i    (rdata_b),
        .fwd_i        (fwd),
        .redirect_i   (redirect),
        .fetch_pc_o   (fetch_pc_o),
        .raddr_a_o    (raddr_a),
        .raddr_b_o    (raddr_b),
        .dec_o        (dec)
    );

    core_execute u_execute (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .dec_i      (dec),
        .fwd_o      (fwd),
        .redirect_o (redirect),
        .res_o      (res)
    );

    core_result u_result (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .res_i      (res),
        .rf_wen_o   (rf_wen),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .retire_o   (retire_o)
    );

    core_regfile u_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .wen_i     (rf_wen),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

endmodule

/* core_asserts.sv */
module core_asserts (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic [31:0]              fetch_pc_i,
    input core_pipe_pkg::retire_t   retire_i,
    input core_pipe_pkg::redirect_t redirect_i
);

    // reset is synchronous, so records are clear from the second reset edge
    retire_quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i [*2] |-> !retire_i.valid)
        else $error("retire_o.valid high while reset is held");

    x0_never_written: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (retire_i.valid && retire_i.rd == 5'd0) |-> !retire_i.wen)
        else $error("retire to x0 with wen set");

    redirect_lands: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_i.taken |=> (fetch_pc_i == $past(redirect_i.target)))
        else $error("fetch pc did not load the redirect target");

endmodule

bind core_top core_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .fetch_pc_i (fetch_pc_o),
    .retire_i   (retire_o),
    .redirect_i (redirect)
);

/* core_tb.sv */
module core_tb;

    localparam int MAX_CYCLES = 400; // ~70 instructions at up to 4 cycles plus drain

    logic                   clk;
    logic                   rst_n;
    logic                   inst_valid;
    logic [31:0]            inst;
    logic [31:0]            fetch_pc;
    core_pipe_pkg::retire_t retire;

    logic [31:0]            prog [0:63];
    int                     prog_len;
    logic                   run_en;
    logic                   bubble_en;
    logic [31:0]            rng_state;
    logic [31:0]            ref_rf [0:31];
    logic [31:0]            ref_pc;
    core_pipe_pkg::retire_t exp_q [$];
    int                     checks;
    int                     val_errs;
    int                     other_errs;
    int                     cycle_cnt;

    core_top #(
        .RESET_PC (32'h0000_0000)
    ) dut_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .fetch_pc_o   (fetch_pc),
        .retire_o     (retire)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] imm_word(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                             logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return imm_word(core_isa_pkg::OPC_OPIMM, 3'd0, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] reg_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                             logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, core_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] upper_word(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] branch_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                                logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, core_isa_pkg::OPC_JAL};
    endfunction

    // RV32I integer op where alt picks sub or sra
    function automatic logic [31:0] ref_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            val_errs++;
            $display("** Error @%0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_counts();
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, val_errs, other_errs);
    endtask

    // one architectural step with its expected retire record
    task automatic ref_step();
        logic [31:0]            ins;
        logic [2:0]             f3;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            imm_i;
        logic [31:0]            res;
        logic [31:0]            next_pc;
        logic                   writes;
        core_pipe_pkg::retire_t exp;
        ins     = prog[ref_pc >> 2];
        f3      = ins[14:12];
        a       = ref_rf[ins[19:15]];
        b       = ref_rf[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        res     = 32'd0;
        writes  = 1'b1;
        next_pc = ref_pc + 32'd4;
        exp     = '0;
        case (ins[6:0])
            core_isa_pkg::OPC_LUI:   res = {ins[31:12], 12'd0};
            core_isa_pkg::OPC_AUIPC: res = ref_pc + {ins[31:12], 12'd0};
            core_isa_pkg::OPC_OPIMM: res = ref_alu(f3, f3 == 3'd5 && ins[30], a, imm_i);
            core_isa_pkg::OPC_OP:    res = ref_alu(f3, ins[30], a, b);
            core_isa_pkg::OPC_JAL: begin
                res     = ref_pc + 32'd4;
                next_pc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            core_isa_pkg::OPC_JALR: begin
                res     = ref_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            core_isa_pkg::OPC_BRANCH: begin
                writes = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    next_pc = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: begin
                writes      = 1'b0;
                exp.illegal = 1'b1;
            end
        endcase
        exp.valid = 1'b1;
        exp.pc    = ref_pc;
        exp.rd    = ins[11:7];
        exp.wen   = writes && (ins[11:7] != 5'd0);
        exp.wdata = res;
        exp_q.push_back(exp);
        if (exp.wen) begin
            ref_rf[exp.rd] = res;
        end
        ref_pc = next_pc;
    endtask

    task automatic ref_run();
        int steps;
        steps = 0;
        while ((ref_pc >> 2) < prog_len && steps < 100) begin
            ref_step();
            steps++;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = bubble_en ? next_rand() : 32'd0;
        if (run_en && (fetch_pc >> 2) < prog_len) begin
            inst       = prog[fetch_pc >> 2];
            inst_valid = ~r[0];
        end else begin
            inst       = 32'h0000_0013; // nop that is not presented
            inst_valid = 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n      = 1'b0;
        run_en     = 1'b0;
        bubble_en  = 1'b0;
        inst_valid = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n    = 1'b1;
        prog_len = 0;
        ref_pc   = 32'd0;
        for (int i = 0; i < 32; i++) begin
            ref_rf[i] = 32'd0;
        end
    endtask

    task automatic run_program();
        run_en = 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            drive_inputs();
        end
        run_en = 1'b0;
        repeat (4) begin // any stray retire shows up here
            @(negedge clk);
            drive_inputs();
        end
    endtask

    task automatic reset_behavior();
        apply_reset();
        compare_field("fetch_pc_o", fetch_pc, 32'd0);
        emit(addi_word(5'd1, 5'd0, 12'h123));
        ref_run();
        repeat (3) begin
            @(negedge clk);
            drive_inputs();
            compare_field("fetch_pc_o", fetch_pc, 32'd0);
            compare_field("retire_o.valid", retire.valid, 32'd0);
        end
        run_en = 1'b1;
        @(negedge clk);
        drive_inputs();
        @(negedge clk); // accepted at the edge just passed
        drive_inputs();
        compare_field("fetch_pc_o", fetch_pc, 32'd4);
        compare_field("retire_o.valid", retire.valid, 32'd0);
        @(negedge clk);
        drive_inputs();
        compare_field("retire_o.valid", retire.valid, 32'd1);
        run_program();
    endtask

    task automatic alu_ops();
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        apply_reset();
        for (int r = 1; r <= 6; r++) begin
            v = next_rand();
            emit(upper_word(core_isa_pkg::OPC_LUI, 5'(r), v[31:12]));
            emit(addi_word(5'(r), 5'(r), v[11:0]));
        end
        for (int k = 0; k < 14; k++) begin
            v   = next_rand();
            rd  = (v[2:0] % 3'd7) + 5'd1;
            rs1 = (v[5:3] % 3'd7) + 5'd1;
            rs2 = (v[8:6] % 3'd7) + 5'd1;
            f3  = v[11:9];
            case (v[13:12])
                2'd0: begin
                    if (f3 == 3'd1) begin
                        imm = {7'd0, v[20:16]};
                    end else if (f3 == 3'd5) begin
                        imm = {1'b0, v[14], 5'd0, v[20:16]}; // srli or srai
                    end else begin
                        imm = v[31:20];
                    end
                    emit(imm_word(core_isa_pkg::OPC_OPIMM, f3, rd, rs1, imm));
                end
                2'd3: emit(upper_word(v[14] ? core_isa_pkg::OPC_AUIPC : core_isa_pkg::OPC_LUI,
                                      rd, v[31:12]));
                default: emit(reg_word(((f3 == 3'd0 || f3 == 3'd5) && v[14]) ? 7'h20 : 7'h00,
                                       f3, rd, rs1, rs2));
            endcase
        end
        v = next_rand();
        emit(upper_word(core_isa_pkg::OPC_AUIPC, 5'd7, v[31:12]));
        ref_run();
        run_program();
    endtask

    task automatic dependent_chain();
        apply_reset();
        emit(addi_word(5'd1, 5'd0, 12'd5));
        emit(addi_word(5'd2, 5'd1, 12'd3));             // distance one
        emit(reg_word(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));  // distance two and one
        emit(reg_word(7'h20, 3'd0, 5'd4, 5'd3, 5'd1));
        emit(reg_word(7'h00, 3'd4, 5'd5, 5'd4, 5'd3));
        emit(reg_word(7'h00, 3'd1, 5'd6, 5'd5, 5'd1));
        emit(addi_word(5'd7, 5'd6, 12'hfff));
        emit(reg_word(7'h00, 3'd2, 5'd1, 5'd7, 5'd6));
        emit(reg_word(7'h00, 3'd6, 5'd2, 5'd1, 5'd7));
        ref_run();
        run_program();
    endtask

    task automatic branch_flow();
        apply_reset();
        emit(addi_word(5'd1, 5'd0, 12'd7));
        emit(addi_word(5'd2, 5'd0, 12'd7));
        emit(branch_word(3'd0, 5'd1, 5'd2, 13'd12)); // beq taken to 20
        emit(addi_word(5'd3, 5'd0, 12'd1));          // wrong path
        emit(addi_word(5'd3, 5'd0, 12'd2));
        emit(branch_word(3'd1, 5'd1, 5'd2, 13'd8));  // bne falls through
        emit(addi_word(5'd4, 5'd0, 12'd9));
        emit(branch_word(3'd4, 5'd0, 5'd1, 13'd8));  // blt taken
        emit(addi_word(5'd5, 5'd0, 12'd1));
        emit(branch_word(3'd7, 5'd0, 5'd1, 13'd8));  // bgeu not taken
        emit(addi_word(5'd6, 5'd4, 12'd1));
        ref_run();
        run_program();
    endtask

    task automatic jump_link();
        apply_reset();
        emit(addi_word(5'd1, 5'd0, 12'd24));
        emit(jal_word(5'd2, 21'd12));                 // to 16
        emit(addi_word(5'd3, 5'd0, 12'd1));
        emit(addi_word(5'd3, 5'd0, 12'd2));
        emit(imm_word(core_isa_pkg::OPC_JALR, 3'd0, 5'd8, 5'd1, 12'd5)); // to 28 with link in x8
        emit(addi_word(5'd4, 5'd0, 12'd3));
        emit(addi_word(5'd4, 5'd0, 12'd4));
        emit(addi_word(5'd0, 5'd0, 12'd77));
        emit(reg_word(7'h00, 3'd0, 5'd5, 5'd0, 5'd2));
        emit(reg_word(7'h00, 3'd0, 5'd6, 5'd0, 5'd0));
        emit(jal_word(5'd7, 21'd8));
        emit(addi_word(5'd3, 5'd0, 12'd3));
        emit(addi_word(5'd9, 5'd7, 12'd0));
        ref_run();
        run_program();
    endtask

    task automatic bubbles_illegal();
        apply_reset();
        bubble_en = 1'b1;
        emit(addi_word(5'd1, 5'd0, 12'd11));
        emit(32'hffff_ffff);                          // unknown opcode with rd x31
        emit(addi_word(5'd2, 5'd1, 12'd1));
        emit(32'h0000_01ff);                          // unknown opcode with rd x3
        emit(reg_word(7'h00, 3'd0, 5'd4, 5'd3, 5'd1));
        emit(reg_word(7'h00, 3'd0, 5'd5, 5'd31, 5'd0));
        ref_run();
        run_program();
    endtask

    always @(negedge clk) begin : retire_monitor
        core_pipe_pkg::retire_t exp;
        if (rst_n && retire.valid) begin
            assert (exp_q.size() != 0) else begin
                other_errs++;
                $display("retire of pc %h arrived with no instruction pending", retire.pc);
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                compare_field("retire_o.pc", retire.pc, exp.pc);
                compare_field("retire_o.rd", retire.rd, exp.rd);
                compare_field("retire_o.wen", retire.wen, exp.wen);
                compare_field("retire_o.illegal", retire.illegal, exp.illegal);
                if (exp.wen) begin
                    compare_field("retire_o.wdata", retire.wdata, exp.wdata);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            other_errs++;
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            report_counts();
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = 32'h0000_0013;
        run_en     = 1'b0;
        bubble_en  = 1'b0;
        rng_state  = 32'd85;
        prog_len   = 0;
        checks     = 0;
        val_errs   = 0;
        other_errs = 0;
        cycle_cnt  = 0;
        reset_behavior();
        alu_ops();
        dependent_chain();
        branch_flow();
        jump_link();
        bubbles_illegal();
        report_counts();
        if (val_errs == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
core_isa_pkg.sv
core_pipe_pkg.sv
core_regfile.sv
core_decode.sv
core_execute.sv
core_result.sv
core_top.sv
core_asserts.sv
core_tb.sv
